// ==== build.f ====
+incdir+verification
src/rob_pkg.sv
src/rob_alloc.sv
src/rob_complete.sv
src/rob_entry_array.sv
src/rob_top.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the reorder buffer testbench with Verilator, run it and grade the log
set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
BUILD_DIR=obj_dir
SIM_BIN=rob_sim

verilator --binary --timing -f build.f --top-module rob_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The testbench prints its pass line on a line of its own
if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, pass line missing in $LOG_FILE"
    exit 1
fi

// ==== src/rob_alloc.sv ====
/*
 * Reorder buffer allocator
 * Tail pointer, free count, per-lane ready and dispatch entry select
 */
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]        dp_req_i,
    input  rob_pkg::rob_ptr_t                             next_head_i,
    input  logic                                          flush_i,
    input  logic                                          exception_i,
    output rob_pkg::dp_rsp_t [rob_pkg::DP_NUM-1:0]        dp_rsp_o,
    output logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_sel_o,
    output logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_lane_o
);

    rob_pkg::rob_ptr_t                      tail;
    rob_pkg::rob_ptr_t                      used_cnt;
    rob_pkg::rob_ptr_t                      free_cnt;
    rob_pkg::rob_ptr_t                      acc_cnt;
    logic              [rob_pkg::DP_NUM-1:0] lane_ready;
    logic              [rob_pkg::DP_NUM-1:0] lane_acc;
    rob_pkg::rob_idx_t [rob_pkg::DP_NUM-1:0] lane_idx;

    // --------------------
    // Free entry count
    // --------------------
    // Wrap bit makes the difference range 0..8
    assign used_cnt = tail - next_head_i;
    // Slots retired this cycle already count as free
    assign free_cnt = rob_pkg::rob_ptr_t'(rob_pkg::ROB_ENTRY_NUM) - used_cnt;

    // --------------------
    // Lane ready and accept
    // --------------------
    always_comb begin
        acc_cnt = '0;
        for (int i = 0; i < rob_pkg::DP_NUM; i++) begin
            // Lane i needs more than i free slots
            lane_ready[i] = free_cnt > rob_pkg::rob_ptr_t'(i);
            // Lane index follows the current tail
            lane_idx[i]   = rob_pkg::rob_idx_t'(tail) + rob_pkg::rob_idx_t'(i);
            // Accept only on an unbroken prefix of lower lanes
            lane_acc[i]   = dp_req_i[i].dp_en && lane_ready[i]
                            && (acc_cnt == rob_pkg::rob_ptr_t'(i));
            if (lane_acc[i]) begin
                acc_cnt = acc_cnt + 1'b1;
            end
        end
    end

    // Response back to dispatch
    always_comb begin
        for (int i = 0; i < rob_pkg::DP_NUM; i++) begin
            dp_rsp_o[i].ready   = lane_ready[i];
            dp_rsp_o[i].rob_idx = lane_idx[i];
        end
    end

    // --------------------
    // Rotated entry select
    // --------------------
    always_comb begin
        dp_sel_o  = '0;
        dp_lane_o = '0;
        for (int i = 0; i < rob_pkg::DP_NUM; i++) begin
            if (lane_acc[i]) begin
                dp_sel_o[lane_idx[i]]  = 1'b1;
                // Source lane of this entry
                dp_lane_o[lane_idx[i]] = 1'(i);
            end
        end
    end

    // Tail returns to zero with the head on any flush
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || exception_i) begin
            tail <= '0;
        end else begin
            tail <= tail + acc_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== src/rob_complete.sv ====
/*
 * Reorder buffer completion matcher
 * Decodes result-lane indices into per-entry completion strobes
 */
`timescale 1ns/1ps
`default_nettype none

module rob_complete (
    input  rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0]       cdb_i,
    output rob_pkg::cp_upd_t [rob_pkg::ROB_ENTRY_NUM-1:0] cp_upd_o
);

    // --------------------
    // Index decode
    // --------------------
    always_comb begin
        for (int e = 0; e < rob_pkg::ROB_ENTRY_NUM; e++) begin
            // Default is no update for this entry
            cp_upd_o[e].strobe    = 1'b0;
            cp_upd_o[e].br_result = 1'b0;
            // Walk lanes upward so the higher lane overrides
            for (int l = 0; l < rob_pkg::CDB_NUM; l++) begin
                if (cdb_i[l].valid
                    && (cdb_i[l].rob_idx == rob_pkg::rob_idx_t'(e))) begin
                    cp_upd_o[e].strobe    = 1'b1;
                    cp_upd_o[e].br_result = cdb_i[l].br_result;
                end
            end
        end
    end

    // Valid and in-flight checks against the entry happen in the array,
    // the matcher only knows indices

endmodule

`default_nettype wire

// ==== src/rob_entry_array.sv ====
/*
 * Reorder buffer entry array
 * Entry storage, head pointer, in-order retire, mispredict flush
 */
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic                                          exception_i,
    input  rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]        dp_req_i,
    input  logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_sel_i,
    input  logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_lane_i,
    input  rob_pkg::cp_upd_t [rob_pkg::ROB_ENTRY_NUM-1:0] cp_upd_i,
    output rob_pkg::rt_out_t [rob_pkg::RT_NUM-1:0]        rt_o,
    output rob_pkg::rob_ptr_t                             next_head_o,
    output logic                                          flush_o
);

    // Entry storage and head
    rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRY_NUM-1:0] entries;
    rob_pkg::rob_ptr_t                                head;

    // Retire selection
    rob_pkg::rob_idx_t [rob_pkg::RT_NUM-1:0]        rt_idx;
    logic              [rob_pkg::RT_NUM-1:0]        rt_vld;
    logic              [rob_pkg::RT_NUM-1:0]        rt_mis;
    logic              [rob_pkg::ROB_ENTRY_NUM-1:0] rt_sel;
    rob_pkg::rob_ptr_t                              rt_cnt;
    // Still retiring in order, nothing stopped the chain yet
    logic                                           chain_ok;
    logic                                           br_flush;

    // --------------------
    // Retire selection
    // --------------------
    always_comb begin
        chain_ok = 1'b1;
        br_flush = 1'b0;
        rt_sel   = '0;
        rt_cnt   = '0;
        for (int r = 0; r < rob_pkg::RT_NUM; r++) begin
            // Consecutive slots from the head
            rt_idx[r] = rob_pkg::rob_idx_t'(head) + rob_pkg::rob_idx_t'(r);
            rt_mis[r] = entries[rt_idx[r]].br_predict != entries[rt_idx[r]].br_result;
            // Exception blocks every lane in its cycle
            rt_vld[r] = chain_ok && !exception_i
                        && entries[rt_idx[r]].valid
                        && entries[rt_idx[r]].complete;
            // A mispredicted branch is the last to retire
            chain_ok  = rt_vld[r] && !rt_mis[r];
            if (rt_vld[r]) begin
                rt_sel[rt_idx[r]] = 1'b1;
                rt_cnt            = rt_cnt + 1'b1;
                if (rt_mis[r]) begin
                    br_flush = 1'b1;
                end
            end
        end
    end

    // Head after this cycle's retires, also used for the free count
    assign next_head_o = head + rt_cnt;
    assign flush_o     = br_flush;

    // --------------------
    // Retire outputs
    // --------------------
    always_comb begin
        for (int r = 0; r < rob_pkg::RT_NUM; r++) begin
            rt_o[r].valid    = rt_vld[r];
            // New mapping for the map table
            rt_o[r].arch_reg = entries[rt_idx[r]].arch_reg;
            rt_o[r].tag      = entries[rt_idx[r]].tag;
            // Old tag goes back to the free list
            rt_o[r].tag_old  = entries[rt_idx[r]].tag_old;
        end
    end

    // --------------------
    // Entry update
    // --------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < rob_pkg::ROB_ENTRY_NUM; e++) begin
            if (rst_i || exception_i || br_flush) begin
                // Whole buffer drops, same-cycle writes are lost
                entries[e].valid    <= 1'b0;
                entries[e].complete <= 1'b0;
            end else if (dp_sel_i[e]) begin
                // New instruction from its source lane
                entries[e].valid      <= 1'b1;
                entries[e].complete   <= 1'b0;
                entries[e].arch_reg   <= dp_req_i[dp_lane_i[e]].arch_reg;
                entries[e].tag        <= dp_req_i[dp_lane_i[e]].tag;
                entries[e].tag_old    <= dp_req_i[dp_lane_i[e]].tag_old;
                entries[e].br_predict <= dp_req_i[dp_lane_i[e]].br_predict;
            end else if (rt_sel[e]) begin
                // Leaves the buffer
                entries[e].valid    <= 1'b0;
                entries[e].complete <= 1'b0;
            end else if (cp_upd_i[e].strobe && entries[e].valid) begin
                // Result arrives, visible to retire next cycle
                entries[e].complete  <= 1'b1;
                entries[e].br_result <= cp_upd_i[e].br_result;
            end
        end
    end

    // Head pointer
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i || br_flush) begin
            head <= '0;
        end else begin
            head <= next_head_o;
        end
    end

endmodule

`default_nettype wire

// ==== src/rob_pkg.sv ====
/*
 * Reorder buffer shared definitions
 * Buffer sizes, index widths and the packed structs passed between blocks
 */
`default_nettype none

package rob_pkg;

    // --------------------
    // Sizes and widths
    // --------------------
    localparam int ROB_ENTRY_NUM  = 8;
    localparam int ROB_IDX_WIDTH  = 3;
    // Dispatch, result and retire lane counts
    localparam int DP_NUM         = 2;
    localparam int CDB_NUM        = 2;
    localparam int RT_NUM         = 2;
    // 32 architectural and 64 physical registers
    localparam int ARCH_REG_WIDTH = 5;
    localparam int TAG_WIDTH      = 6;

    // --------------------
    // Index and pointer types
    // --------------------
    // Plain entry index
    typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;
    // Entry index plus wrap bit, tells full from empty
    typedef logic [ROB_IDX_WIDTH:0] rob_ptr_t;

    // --------------------
    // Lane and entry structs
    // --------------------
    // One dispatch lane from the front end
    typedef struct packed {
        logic                      dp_en;
        logic [ARCH_REG_WIDTH-1:0] arch_reg;
        logic [TAG_WIDTH-1:0]      tag;
        logic [TAG_WIDTH-1:0]      tag_old;
        logic                      br_predict;
    } dp_req_t;

    // Dispatch response, index valid while ready is high
    typedef struct packed {
        logic     ready;
        rob_idx_t rob_idx;
    } dp_rsp_t;

    // One result broadcast lane
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     br_result;
    } cdb_t;

    // Per-entry completion update
    typedef struct packed {
        logic strobe;
        logic br_result;
    } cp_upd_t;

    // Stored entry
    typedef struct packed {
        logic                      valid;
        logic                      complete;
        logic [ARCH_REG_WIDTH-1:0] arch_reg;
        logic [TAG_WIDTH-1:0]      tag;
        logic [TAG_WIDTH-1:0]      tag_old;
        logic                      br_predict;
        logic                      br_result;
    } rob_entry_t;

    // One retire lane, to map table and free list
    typedef struct packed {
        logic                      valid;
        logic [ARCH_REG_WIDTH-1:0] arch_reg;
        logic [TAG_WIDTH-1:0]      tag;
        logic [TAG_WIDTH-1:0]      tag_old;
    } rt_out_t;

endpackage

`default_nettype wire

// ==== src/rob_top.sv ====
/*
 * Reorder buffer top level
 * Two-wide dispatch, two result lanes and two-wide in-order retire
 */
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   exception_i,
    // Dispatch side
    input  rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]  dp_req_i,
    output rob_pkg::dp_rsp_t [rob_pkg::DP_NUM-1:0]  dp_rsp_o,
    // Result broadcast
    input  rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0] cdb_i,
    // Retire to map table and free list
    output rob_pkg::rt_out_t [rob_pkg::RT_NUM-1:0]  rt_o
);

    // --------------------
    // Internal wiring
    // --------------------
    // Allocator to array
    logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_sel;
    logic             [rob_pkg::ROB_ENTRY_NUM-1:0] dp_lane;
    // Matcher to array
    rob_pkg::cp_upd_t [rob_pkg::ROB_ENTRY_NUM-1:0] cp_upd;
    // Array back to allocator
    rob_pkg::rob_ptr_t                             next_head;
    logic                                          flush;

    // Tail side
    rob_alloc u_alloc (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dp_req_i    (dp_req_i),
        .next_head_i (next_head),
        .flush_i     (flush),
        .exception_i (exception_i),
        .dp_rsp_o    (dp_rsp_o),
        .dp_sel_o    (dp_sel),
        .dp_lane_o   (dp_lane)
    );

    // Result side
    rob_complete u_complete (
        .cdb_i    (cdb_i),
        .cp_upd_o (cp_upd)
    );

    // Storage, retire and flush
    rob_entry_array u_array (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .dp_req_i    (dp_req_i),
        .dp_sel_i    (dp_sel),
        .dp_lane_i   (dp_lane),
        .cp_upd_i    (cp_upd),
        .rt_o        (rt_o),
        .next_head_o (next_head),
        .flush_o     (flush)
    );

endmodule

`default_nettype wire

// ==== verification/rob_model.svh ====
/*
 * Reorder buffer reference model
 * Entry state, head and tail, and the expected outputs of the current cycle
 */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// --------------------
// Model state
// --------------------
rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRY_NUM-1:0] m_ent;
// Pointers run over twice the entry count with the top bit as wrap
int m_head;
int m_tail;

// Expected outputs for the present inputs
logic [rob_pkg::RT_NUM-1:0] exp_rt_vld;
int                         exp_rt_idx [rob_pkg::RT_NUM];
int                         exp_rt_cnt;
logic                       exp_flush;
int                         exp_free;

// Run statistics
int n_retired;
int n_flush;
int n_exc;

task automatic model_reset();
    m_ent     = '0;
    m_head    = 0;
    m_tail    = 0;
    n_retired = 0;
    n_flush   = 0;
    n_exc     = 0;
endtask

// Retire lanes, flush and free count from the stored state
task automatic compute_expect(input logic exc);
    int   idx;
    logic chain;
    chain      = 1'b1;
    exp_flush  = 1'b0;
    exp_rt_cnt = 0;
    for (int r = 0; r < rob_pkg::RT_NUM; r++) begin
        idx           = (m_head + r) % rob_pkg::ROB_ENTRY_NUM;
        exp_rt_idx[r] = idx;
        // In order from the head and all blocked by an exception
        exp_rt_vld[r] = chain && !exc && m_ent[idx].valid && m_ent[idx].complete;
        if (exp_rt_vld[r]) begin
            exp_rt_cnt++;
            if (m_ent[idx].br_predict != m_ent[idx].br_result) begin
                exp_flush = 1'b1;
            end
        end
        // Stop after a gap or after a mispredicted branch
        chain = exp_rt_vld[r] && !exp_flush;
    end
    // Slots retiring this cycle already count as free
    exp_free = rob_pkg::ROB_ENTRY_NUM
               - ((m_tail - m_head - exp_rt_cnt + 4 * rob_pkg::ROB_ENTRY_NUM)
                  % (2 * rob_pkg::ROB_ENTRY_NUM));
endtask

// Clock edge with the inputs held during the cycle
task automatic model_step(
    input rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]  req,
    input rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0] cdb,
    input logic                                    exc
);
    int                                idx;
    int                                acc;
    logic [rob_pkg::ROB_ENTRY_NUM-1:0] gone;
    compute_expect(exc);
    n_retired += exp_rt_cnt;
    if (exc || exp_flush) begin
        // Whole buffer empties and this cycle's writes are lost
        for (int e = 0; e < rob_pkg::ROB_ENTRY_NUM; e++) begin
            m_ent[e].valid    = 1'b0;
            m_ent[e].complete = 1'b0;
        end
        m_head = 0;
        m_tail = 0;
        if (exc) begin
            n_exc++;
        end else begin
            n_flush++;
        end
    end else begin
        gone = '0;
        for (int r = 0; r < rob_pkg::RT_NUM; r++) begin
            if (exp_rt_vld[r]) begin
                gone[exp_rt_idx[r]] = 1'b1;
            end
        end
        // Results land only on entries that stay with lane 1 applied last
        for (int l = 0; l < rob_pkg::CDB_NUM; l++) begin
            idx = int'(cdb[l].rob_idx);
            if (cdb[l].valid && m_ent[idx].valid && !gone[idx]) begin
                m_ent[idx].complete  = 1'b1;
                m_ent[idx].br_result = cdb[l].br_result;
            end
        end
        for (int e = 0; e < rob_pkg::ROB_ENTRY_NUM; e++) begin
            if (gone[e]) begin
                m_ent[e].valid    = 1'b0;
                m_ent[e].complete = 1'b0;
            end
        end
        // Dispatch on a ready lower-lane prefix that may reuse a retiring slot
        acc = 0;
        for (int i = 0; i < rob_pkg::DP_NUM; i++) begin
            if (req[i].dp_en && exp_free > i && acc == i) begin
                idx                   = (m_tail + i) % rob_pkg::ROB_ENTRY_NUM;
                m_ent[idx].valid      = 1'b1;
                m_ent[idx].complete   = 1'b0;
                m_ent[idx].arch_reg   = req[i].arch_reg;
                m_ent[idx].tag        = req[i].tag;
                m_ent[idx].tag_old    = req[i].tag_old;
                m_ent[idx].br_predict = req[i].br_predict;
                acc++;
            end
        end
        m_head = (m_head + exp_rt_cnt) % (2 * rob_pkg::ROB_ENTRY_NUM);
        m_tail = (m_tail + acc) % (2 * rob_pkg::ROB_ENTRY_NUM);
    end
endtask

`endif

// ==== verification/rob_tb.sv ====
/*
 * Reorder buffer testbench
 * Random dispatch, completion and exception traffic checked against a model
 */
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    localparam int          CLK_PERIOD     = 40;
    localparam int          RESET_CYCLES   = 16;
    localparam int          RUN_CYCLES     = 3000;
    // Run length plus a third as margin
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
    localparam int unsigned LCG_SEED       = 28028;

    logic                                          clk_i;
    logic                                          rst_i;
    logic                                          exception_i;
    rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]        dp_req_i;
    rob_pkg::dp_rsp_t [rob_pkg::DP_NUM-1:0]        dp_rsp_o;
    rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0]       cdb_i;
    rob_pkg::rt_out_t [rob_pkg::RT_NUM-1:0]        rt_o;

    int unsigned lcg_state = LCG_SEED;
    int          cycle_cnt = 0;
    int          n_full    = 0;

    `include "rob_model.svh"

    rob_top u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .dp_req_i    (dp_req_i),
        .dp_rsp_o    (dp_rsp_o),
        .cdb_i       (cdb_i),
        .rt_o        (rt_o)
    );

    // --------------------
    // Clock and timeout
    // --------------------
    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Linear congruential generator returning its upper bits
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // --------------------
    // Output checks
    // --------------------
    task automatic check_outputs();
        int idx;
        compute_expect(exception_i);
        if (exp_free == 0) begin
            n_full++;
        end
        for (int i = 0; i < rob_pkg::DP_NUM; i++) begin
            check_val($sformatf("dispatch lane %0d ready", i),
                      int'(dp_rsp_o[i].ready), (exp_free > i) ? 1 : 0);
            // Index only means something while ready
            if (exp_free > i) begin
                check_val($sformatf("dispatch lane %0d rob_idx", i),
                          int'(dp_rsp_o[i].rob_idx), (m_tail + i) % rob_pkg::ROB_ENTRY_NUM);
            end
        end
        for (int r = 0; r < rob_pkg::RT_NUM; r++) begin
            idx = exp_rt_idx[r];
            check_val($sformatf("retire lane %0d valid", r),
                      int'(rt_o[r].valid), int'(exp_rt_vld[r]));
            if (exp_rt_vld[r]) begin
                check_val($sformatf("retire lane %0d arch_reg", r),
                          int'(rt_o[r].arch_reg), int'(m_ent[idx].arch_reg));
                check_val($sformatf("retire lane %0d tag", r),
                          int'(rt_o[r].tag), int'(m_ent[idx].tag));
                check_val($sformatf("retire lane %0d tag_old", r),
                          int'(rt_o[r].tag_old), int'(m_ent[idx].tag_old));
            end
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic drive_stimulus();
        int unsigned                            r;
        logic                                   nxt_exc;
        int                                     n_dp;
        int                                     pick;
        int                                     cand [$];
        rob_pkg::dp_req_t [rob_pkg::DP_NUM-1:0]  nxt_req;
        rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0] nxt_cdb;
        nxt_req = '0;
        nxt_cdb = '0;
        // Exception about once in 200 cycles
        nxt_exc = (next_rand() % 200) == 0;
        // Distinct results for valid entries still waiting
        for (int e = 0; e < rob_pkg::ROB_ENTRY_NUM; e++) begin
            if (m_ent[e].valid && !m_ent[e].complete) begin
                cand.push_back(e);
            end
        end
        for (int l = 0; l < rob_pkg::CDB_NUM; l++) begin
            if (cand.size() > 0 && (next_rand() % 4) != 0) begin
                pick                 = int'(next_rand() % cand.size());
                r                    = next_rand();
                nxt_cdb[l].valid     = 1'b1;
                nxt_cdb[l].rob_idx   = rob_pkg::rob_idx_t'(cand[pick]);
                // Mispredict about one time in sixteen
                nxt_cdb[l].br_result = m_ent[cand[pick]].br_predict ^ ((r % 16) == 0);
                cand.delete(pick);
            end
        end
        // Dispatch count bounded by the free count of the coming cycle
        compute_expect(nxt_exc);
        n_dp = int'(next_rand() % 3);
        if (n_dp > exp_free) begin
            n_dp = exp_free;
        end
        for (int i = 0; i < n_dp; i++) begin
            r                     = next_rand();
            nxt_req[i].dp_en      = 1'b1;
            nxt_req[i].arch_reg   = r[4:0];
            nxt_req[i].tag        = r[10:5];
            nxt_req[i].tag_old    = r[16:11];
            nxt_req[i].br_predict = r[17];
        end
        dp_req_i    <= nxt_req;
        cdb_i       <= nxt_cdb;
        exception_i <= nxt_exc;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_i       <= 1'b1;
        exception_i <= 1'b0;
        dp_req_i    <= '0;
        cdb_i       <= '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            // Outputs settle by mid cycle
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            model_step(dp_req_i, cdb_i, exception_i);
            drive_stimulus();
        end
        $display("Retired %0d, mispredict flushes %0d, exceptions %0d, full cycles %0d",
                 n_retired, n_flush, n_exc, n_full);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
